// File: compile.f
+incdir+verification
logic/fabricPkg.sv
logic/wbAddrDecoder.sv
logic/fpgaRegisters.sv
logic/ramBanks.sv
logic/reservedBlock.sv
logic/fabricTop.sv
verification/fabricTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the fabric testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module fabricTb -o fabricSim \
    && ./obj_dir/fabricSim | tee /dev/stderr | grep -q "Test passed" \
    && echo "Simulation run OK" \
    || { echo "Simulation run FAILED"; exit 1; }

// File: verification/fabricModel.svh
// Reference model of the fabric registers, RAM banks and address regions with typed compare tasks
`ifndef FABRIC_MODEL_SVH
`define FABRIC_MODEL_SVH

// --------------------
// Model state
// --------------------

fabricPkg::gpio_t gpioOutModel = '0;
fabricPkg::gpio_t gpioOeModel  = '0;
// Value last driven on the GPIO input pins
fabricPkg::gpio_t gpioInModel  = '0;

// Only words already written, keyed by region and word offset
fabricPkg::word_t ramModel [int];

function automatic int ramKey(input fabricPkg::busAdr_t adr);
    return int'({adr[fabricPkg::ADDR_WIDTH-1:fabricPkg::REGION_LSB], adr[RAM_ADDR_WIDTH+1:2]});
endfunction

// Strobed lanes take new data, the rest keep the old word
function automatic fabricPkg::word_t mergeBytes(input fabricPkg::word_t oldWord,
                                                input fabricPkg::word_t newWord,
                                                input fabricPkg::byteStb_t lanes);
    fabricPkg::word_t merged;
    merged = oldWord;
    for (int lane = 0; lane < 4; lane++)
    begin
        if (lanes[lane])
        begin
            merged[lane*8 +: 8] = newWord[lane*8 +: 8];
        end
    end
    return merged;
endfunction

// Read value by region and word offset
function automatic fabricPkg::word_t expectedRead(input fabricPkg::busAdr_t adr);
    logic [3:0] region;
    logic [6:0] wordOff;
    region  = adr[fabricPkg::ADDR_WIDTH-1:fabricPkg::REGION_LSB];
    wordOff = adr[fabricPkg::REG_ADDR_WIDTH+1:2];
    case (region)
        fabricPkg::REG_REGION:
        begin
            case (wordOff)
                fabricPkg::ID_ADR:       return DEVICE_ID;
                fabricPkg::REV_ADR:      return REV_LEVEL;
                fabricPkg::GPIO_IN_ADR:  return {24'h0, gpioInModel};
                fabricPkg::GPIO_OUT_ADR: return {24'h0, gpioOutModel};
                fabricPkg::GPIO_OE_ADR:  return {24'h0, gpioOeModel};
                default:                 return fabricPkg::REG_DEF_VALUE;
            endcase
        end
        fabricPkg::RAM0_REGION, fabricPkg::RAM1_REGION,
        fabricPkg::RAM2_REGION, fabricPkg::RAM3_REGION:
        begin
            return ramModel[ramKey(adr)];
        end
        fabricPkg::RESERVED_REGION:
        begin
            case (wordOff)
                fabricPkg::CUST_PROD_ADR: return {16'h0, CUSTOMER_ID, PRODUCT_ID};
                fabricPkg::REVISIONS_ADR: return {MAJOR_REV, MINOR_REV};
                default:                  return fabricPkg::RSV_DEF_VALUE;
            endcase
        end
        default:
        begin
            return fabricPkg::DEFAULT_READ_VALUE;
        end
    endcase
endfunction

// Only GPIO lane 0 and the RAM banks hold written data
function automatic void applyWrite(input fabricPkg::busAdr_t adr,
                                   input fabricPkg::byteStb_t lanes,
                                   input fabricPkg::word_t data);
    logic [3:0]       region;
    logic [6:0]       wordOff;
    fabricPkg::word_t oldWord;
    region  = adr[fabricPkg::ADDR_WIDTH-1:fabricPkg::REGION_LSB];
    wordOff = adr[fabricPkg::REG_ADDR_WIDTH+1:2];
    if (region == fabricPkg::REG_REGION && lanes[0])
    begin
        if (wordOff == fabricPkg::GPIO_OUT_ADR)
            gpioOutModel = data[7:0];
        if (wordOff == fabricPkg::GPIO_OE_ADR)
            gpioOeModel = data[7:0];
    end
    else if (region >= fabricPkg::RAM0_REGION && region <= fabricPkg::RAM3_REGION)
    begin
        oldWord = ramModel.exists(ramKey(adr)) ? ramModel[ramKey(adr)] : '0;
        ramModel[ramKey(adr)] = mergeBytes(oldWord, data, lanes);
    end
endfunction

// --------------------
// Compare tasks
// --------------------

task automatic reportAndStop(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Stopped at the first mismatch");
endtask

task automatic checkWord(input string testName, input fabricPkg::word_t expected,
                         input fabricPkg::word_t actual);
    if (actual !== expected)
        reportAndStop($sformatf("Fail %s: expected %h, actual %h", testName, expected, actual));
endtask

task automatic checkGpio(input string testName, input fabricPkg::gpio_t expected,
                         input fabricPkg::gpio_t actual);
    if (actual !== expected)
        reportAndStop($sformatf("Fail %s: expected %h, actual %h", testName, expected, actual));
endtask

`endif

// File: verification/fabricTb.sv
// Testbench for the bus fabric driving random accesses checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module fabricTb;

    localparam int          CLK_PERIOD     = 8;
    localparam int          DRIVE_DELAY    = 1;
    localparam int          RESET_CYCLES   = 5;
    localparam int          RAM_ADDR_WIDTH = 8;
    localparam int          TIMEOUT_CYCLES = 7;
    localparam logic [31:0] DEVICE_ID      = 32'hC0DE_0A17;
    localparam logic [31:0] REV_LEVEL      = 32'h0002_0301;
    localparam logic [7:0]  CUSTOMER_ID    = 8'h5A;
    localparam logic [7:0]  PRODUCT_ID     = 8'h3C;
    localparam logic [15:0] MAJOR_REV      = 16'h0002;
    localparam logic [15:0] MINOR_REV      = 16'h0011;

    localparam int RAM_WRITES   = 200;
    // Id 20, GPIO 72, RAM 400, banks 16, unmapped 42
    localparam int NUM_ACCESSES = 550;
    localparam int WATCHDOG_NS  = NUM_ACCESSES * (TIMEOUT_CYCLES + 4) * CLK_PERIOD
                                  + RESET_CYCLES * CLK_PERIOD;

    logic                wbClk;
    logic                rst;
    logic                cyc;
    logic                stb;
    logic                we;
    fabricPkg::busAdr_t  busAdr;
    fabricPkg::byteStb_t byteStb;
    fabricPkg::word_t    wrDat;
    fabricPkg::word_t    rdDat;
    logic                ack;
    fabricPkg::gpio_t    gpioIn;
    fabricPkg::gpio_t    gpioOut;
    fabricPkg::gpio_t    gpioOe;

    integer             seed = 32'h7a96_f230;
    // Every RAM address written by the random test
    fabricPkg::busAdr_t ramAdrs[$];

    `include "fabricModel.svh"

    fabricTop #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
        .DEVICE_ID      (DEVICE_ID),
        .REV_LEVEL      (REV_LEVEL),
        .CUSTOMER_ID    (CUSTOMER_ID),
        .PRODUCT_ID     (PRODUCT_ID),
        .MAJOR_REV      (MAJOR_REV),
        .MINOR_REV      (MINOR_REV)
    ) dut_i (
        .wbClk_i   (wbClk),
        .rst_i     (rst),
        .cyc_i     (cyc),
        .stb_i     (stb),
        .we_i      (we),
        .adr_i     (busAdr),
        .byteStb_i (byteStb),
        .wrDat_i   (wrDat),
        .rdDat_o   (rdDat),
        .ack_o     (ack),
        .gpioIn_i  (gpioIn),
        .gpioOut_o (gpioOut),
        .gpioOe_o  (gpioOe)
    );

    initial
    begin
        wbClk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2);
            wbClk = ~wbClk;
        end
    end

    // --------------------
    // Address helpers
    // --------------------

    function automatic fabricPkg::busAdr_t makeAdr(input logic [3:0] region,
                                                   input int unsigned wordOff);
        return {region, 11'(wordOff), 2'b00};
    endfunction

    // Offsets spread over the whole bank from 0 to 255
    function automatic fabricPkg::busAdr_t ramAdr(input int bank, input int idx);
        return makeAdr(4'(bank + 1), idx * 17);
    endfunction

    // Region 5 or 7 to 15
    function automatic logic [3:0] unmappedRegion();
        int pick;
        pick = $unsigned($random(seed)) % 10;
        return (pick == 0) ? 4'd5 : 4'(pick + 6);
    endfunction

    // --------------------
    // Bus tasks
    // --------------------

    // Called and returns at DRIVE_DELAY after a rising edge
    task automatic accessBus(input logic write, input fabricPkg::busAdr_t adr,
                             input fabricPkg::byteStb_t lanes, input fabricPkg::word_t data,
                             output fabricPkg::word_t readBack);
        cyc     = 1'b1;
        stb     = 1'b1;
        we      = write;
        busAdr  = adr;
        byteStb = lanes;
        wrDat   = data;
        // Wait for the ack cycle
        do
        begin
            @(posedge wbClk);
            #DRIVE_DELAY;
        end
        while (ack !== 1'b1);
        // Read data is valid in the ack cycle
        readBack = rdDat;
        // Request stays up until the edge that samples the ack
        @(posedge wbClk);
        #DRIVE_DELAY;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        // Idle cycle before the next request
        @(posedge wbClk);
        #DRIVE_DELAY;
    endtask

    task automatic writeWord(input fabricPkg::busAdr_t adr, input fabricPkg::byteStb_t lanes,
                             input fabricPkg::word_t data);
        fabricPkg::word_t ignored;
        accessBus(1'b1, adr, lanes, data, ignored);
        applyWrite(adr, lanes, data);
    endtask

    task automatic readCheck(input string testName, input fabricPkg::busAdr_t adr);
        fabricPkg::word_t readData;
        accessBus(1'b0, adr, 4'hF, '0, readData);
        checkWord(testName, expectedRead(adr), readData);
    endtask

    // --------------------
    // Tests
    // --------------------

    task automatic verifyIdWords();
        fabricPkg::busAdr_t fixedAdrs[4];
        fixedAdrs[0] = makeAdr(fabricPkg::REG_REGION, int'(fabricPkg::ID_ADR));
        fixedAdrs[1] = makeAdr(fabricPkg::REG_REGION, int'(fabricPkg::REV_ADR));
        fixedAdrs[2] = makeAdr(fabricPkg::RESERVED_REGION, int'(fabricPkg::CUST_PROD_ADR));
        fixedAdrs[3] = makeAdr(fabricPkg::RESERVED_REGION, int'(fabricPkg::REVISIONS_ADR));
        foreach (fixedAdrs[i])
            readCheck("id word", fixedAdrs[i]);
        // Read-only words ignore writes
        foreach (fixedAdrs[i])
        begin
            writeWord(fixedAdrs[i], 4'hF, fabricPkg::word_t'($random(seed)));
            readCheck("id word after write", fixedAdrs[i]);
        end
        repeat (4)
        begin
            readCheck("undefined register",
                      makeAdr(fabricPkg::REG_REGION, 5 + $unsigned($random(seed)) % 123));
            readCheck("undefined reserved",
                      makeAdr(fabricPkg::RESERVED_REGION, $unsigned($random(seed)) % 126));
        end
    endtask

    task automatic exerciseGpio();
        fabricPkg::busAdr_t outAdr;
        fabricPkg::busAdr_t oeAdr;
        outAdr = makeAdr(fabricPkg::REG_REGION, int'(fabricPkg::GPIO_OUT_ADR));
        oeAdr  = makeAdr(fabricPkg::REG_REGION, int'(fabricPkg::GPIO_OE_ADR));
        repeat (16)
        begin
            writeWord(outAdr, fabricPkg::byteStb_t'($random(seed)),
                      fabricPkg::word_t'($random(seed)));
            writeWord(oeAdr, fabricPkg::byteStb_t'($random(seed)),
                      fabricPkg::word_t'($random(seed)));
            readCheck("gpio out register", outAdr);
            readCheck("gpio oe register", oeAdr);
            checkGpio("gpio out pins", gpioOutModel, gpioOut);
            checkGpio("gpio oe pins", gpioOeModel, gpioOe);
        end
        // Three cycles clear the two synchronizer flops
        repeat (8)
        begin
            gpioIn      = fabricPkg::gpio_t'($random(seed));
            gpioInModel = gpioIn;
            repeat (3) @(posedge wbClk);
            #DRIVE_DELAY;
            readCheck("gpio input", makeAdr(fabricPkg::REG_REGION, int'(fabricPkg::GPIO_IN_ADR)));
        end
    endtask

    // Sixteen words per bank so writes land on the same word again
    task automatic randomRam();
        fabricPkg::busAdr_t  adr;
        fabricPkg::byteStb_t lanes;
        repeat (RAM_WRITES)
        begin
            adr = ramAdr($unsigned($random(seed)) % 4, $unsigned($random(seed)) % 16);
            // Memory starts unknown so the first write fills all lanes
            lanes = ramModel.exists(ramKey(adr)) ? fabricPkg::byteStb_t'($random(seed)) : 4'hF;
            writeWord(adr, lanes, fabricPkg::word_t'($random(seed)));
            ramAdrs.push_back(adr);
        end
        foreach (ramAdrs[i])
            readCheck("ram read back", ramAdrs[i]);
    endtask

    task automatic bankIndependence();
        int offsets[2] = '{3, 15};
        foreach (offsets[k])
        begin
            // Top byte carries the bank number
            for (int bank = 0; bank < fabricPkg::NUM_RAM_BANKS; bank++)
                writeWord(ramAdr(bank, offsets[k]), 4'hF, {8'(bank), 24'($random(seed))});
            for (int bank = 0; bank < fabricPkg::NUM_RAM_BANKS; bank++)
                readCheck("bank independence", ramAdr(bank, offsets[k]));
        end
    endtask

    task automatic unmappedAccess();
        repeat (16)
        begin
            writeWord(makeAdr(unmappedRegion(), $unsigned($random(seed)) % 2048),
                      fabricPkg::byteStb_t'($random(seed)), fabricPkg::word_t'($random(seed)));
            readCheck("unmapped read", makeAdr(unmappedRegion(), $unsigned($random(seed)) % 2048));
        end
        // No real target may have changed
        readCheck("gpio out kept", makeAdr(fabricPkg::REG_REGION, int'(fabricPkg::GPIO_OUT_ADR)));
        readCheck("gpio oe kept", makeAdr(fabricPkg::REG_REGION, int'(fabricPkg::GPIO_OE_ADR)));
        for (int i = 0; i < 8; i++)
            readCheck("ram kept", ramAdrs[i]);
    endtask

    initial
    begin
        rst     = 1'b1;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
        busAdr  = '0;
        byteStb = '0;
        wrDat   = '0;
        gpioIn  = '0;
        repeat (RESET_CYCLES) @(posedge wbClk);
        #DRIVE_DELAY;
        rst = 1'b0;
        checkGpio("gpio out after reset", '0, gpioOut);
        checkGpio("gpio oe after reset", '0, gpioOe);
        @(posedge wbClk);
        #DRIVE_DELAY;
        verifyIdWords();
        exerciseGpio();
        randomRam();
        bankIndependence();
        unmappedAccess();
        $display("Test passed");
        $finish;
    end

    // Worst case is a timeout on every access
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the accesses did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $fatal(1, "Run ended by the watchdog");
    end

endmodule

`default_nettype wire

// File: logic/fabricTop.sv
// Fabric top level joining the bus decoder, registers, RAM banks and reserved block
`timescale 1ns/1ps
`default_nettype none

module fabricTop #(
    parameter int          RAM_ADDR_WIDTH = 8,
    parameter int          TIMEOUT_CYCLES = 7,
    parameter logic [31:0] DEVICE_ID      = 32'h0000_F0B5,
    parameter logic [31:0] REV_LEVEL      = 32'h0000_0100,
    parameter logic [7:0]  CUSTOMER_ID    = 8'h01,
    parameter logic [7:0]  PRODUCT_ID     = 8'h00,
    parameter logic [15:0] MAJOR_REV      = 16'h0001,
    parameter logic [15:0] MINOR_REV      = 16'h0000
) (
    input  logic               wbClk_i,
    input  logic               rst_i,
    // Bus slave port
    input  logic               cyc_i,
    input  logic               stb_i,
    input  logic               we_i,
    input  fabricPkg::busAdr_t  adr_i,
    input  fabricPkg::byteStb_t byteStb_i,
    input  fabricPkg::word_t    wrDat_i,
    output fabricPkg::word_t    rdDat_o,
    output logic               ack_o,
    // GPIO, pads live outside
    input  fabricPkg::gpio_t    gpioIn_i,
    output fabricPkg::gpio_t    gpioOut_o,
    output fabricPkg::gpio_t    gpioOe_o
);

    // --------------------
    // Target wiring
    // --------------------

    logic                                regCyc;
    logic                                rsvCyc;
    logic [fabricPkg::NUM_RAM_BANKS-1:0] ramCyc;

    logic regAck;
    logic ramAck;
    logic rsvAck;

    fabricPkg::word_t regDat;
    fabricPkg::word_t ramDat;
    fabricPkg::word_t rsvDat;

    // Region select, ack merge and read mux
    wbAddrDecoder decoder_i (
        .adr_i     (adr_i),
        .cyc_i     (cyc_i),
        .regDat_i  (regDat),
        .ramDat_i  (ramDat),
        .rsvDat_i  (rsvDat),
        .regAck_i  (regAck),
        .ramAck_i  (ramAck),
        .rsvAck_i  (rsvAck),
        .regCyc_o  (regCyc),
        .rsvCyc_o  (rsvCyc),
        .ramCyc_o  (ramCyc),
        .rdDat_o   (rdDat_o),
        .ack_o     (ack_o)
    );

    // Word offsets drop the byte bits
    fpgaRegisters #(
        .DEVICE_ID (DEVICE_ID),
        .REV_LEVEL (REV_LEVEL)
    ) registers_i (
        .wbClk_i   (wbClk_i),
        .rst_i     (rst_i),
        .cyc_i     (regCyc),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .wordAdr_i (adr_i[fabricPkg::REG_ADDR_WIDTH+1:2]),
        .byteStb_i (byteStb_i),
        .wrDat_i   (wrDat_i),
        .rdDat_o   (regDat),
        .ack_o     (regAck),
        .gpioIn_i  (gpioIn_i),
        .gpioOut_o (gpioOut_o),
        .gpioOe_o  (gpioOe_o)
    );

    ramBanks #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) ramBanks_i (
        .wbClk_i   (wbClk_i),
        .rst_i     (rst_i),
        .bankCyc_i (ramCyc),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .wordAdr_i (adr_i[RAM_ADDR_WIDTH+1:2]),
        .byteStb_i (byteStb_i),
        .wrDat_i   (wrDat_i),
        .rdDat_o   (ramDat),
        .ack_o     (ramAck)
    );

    // Timeout watches the merged ack and the raw cycle
    reservedBlock #(
        .CUSTOMER_ID    (CUSTOMER_ID),
        .PRODUCT_ID     (PRODUCT_ID),
        .MAJOR_REV      (MAJOR_REV),
        .MINOR_REV      (MINOR_REV),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) reserved_i (
        .wbClk_i   (wbClk_i),
        .rst_i     (rst_i),
        .rsvCyc_i  (rsvCyc),
        .cyc_i     (cyc_i),
        .stb_i     (stb_i),
        .busAck_i  (ack_o),
        .wordAdr_i (adr_i[fabricPkg::REG_ADDR_WIDTH+1:2]),
        .rdDat_o   (rsvDat),
        .ack_o     (rsvAck)
    );

endmodule

`default_nettype wire

// File: logic/reservedBlock.sv
// Reserved block with customer, product and revision words plus the bus timeout FSM
`timescale 1ns/1ps
`default_nettype none

module reservedBlock #(
    parameter logic [7:0]  CUSTOMER_ID    = 8'h01,
    parameter logic [7:0]  PRODUCT_ID     = 8'h00,
    parameter logic [15:0] MAJOR_REV      = 16'h0001,
    parameter logic [15:0] MINOR_REV      = 16'h0000,
    parameter int          TIMEOUT_CYCLES = 7
) (
    input  logic                                 wbClk_i,
    input  logic                                 rst_i,
    input  logic                                 rsvCyc_i,
    // Raw bus cycle and merged ack for the timeout
    input  logic                                 cyc_i,
    input  logic                                 stb_i,
    input  logic                                 busAck_i,
    input  logic [fabricPkg::REG_ADDR_WIDTH-1:0] wordAdr_i,
    output fabricPkg::word_t                     rdDat_o,
    output logic                                 ack_o
);

    // Count range reaches past TIMEOUT_CYCLES
    localparam int CNT_WIDTH = $clog2(TIMEOUT_CYCLES + 2);

    typedef enum logic {
        TO_IDLE,
        TO_COUNT
    } toState_e;

    toState_e             toState;
    logic [CNT_WIDTH-1:0] toCnt;
    logic                 toAckQ;
    logic                 rsvAckQ;
    logic                 pending;

    // Own region answers in one cycle
    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            rsvAckQ <= 1'b0;
        end
        else
        begin
            rsvAckQ <= rsvCyc_i && stb_i && !rsvAckQ;
        end
    end

    always_comb
    begin
        case (fabricPkg::rsvAddr_e'(wordAdr_i))
            fabricPkg::CUST_PROD_ADR: rdDat_o = {16'h0, CUSTOMER_ID, PRODUCT_ID};
            fabricPkg::REVISIONS_ADR: rdDat_o = {MAJOR_REV, MINOR_REV};
            default:                  rdDat_o = fabricPkg::RSV_DEF_VALUE;
        endcase
    end

    // --------------------
    // Bus timeout
    // --------------------

    // Request nobody has answered yet
    assign pending = cyc_i && stb_i && !busAck_i;

    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            toState <= TO_IDLE;
            toCnt   <= '0;
            toAckQ  <= 1'b0;
        end
        else
        begin
            // Ack pulse lasts one cycle only
            toAckQ <= 1'b0;
            case (toState)
                TO_IDLE:
                begin
                    if (pending)
                    begin
                        toState <= TO_COUNT;
                        toCnt   <= CNT_WIDTH'(1);
                    end
                end
                TO_COUNT:
                begin
                    if (!pending)
                    begin
                        // Some target answered or master gave up
                        toState <= TO_IDLE;
                        toCnt   <= '0;
                    end
                    else if (toCnt == CNT_WIDTH'(TIMEOUT_CYCLES))
                    begin
                        toAckQ  <= 1'b1;
                        toState <= TO_IDLE;
                        toCnt   <= '0;
                    end
                    else
                    begin
                        toCnt <= toCnt + 1'b1;
                    end
                end
                default:
                begin
                    toState <= TO_IDLE;
                end
            endcase
        end
    end

    assign ack_o = rsvAckQ | toAckQ;

    cntBound: assert property (@(posedge wbClk_i) disable iff (rst_i)
        toCnt <= CNT_WIDTH'(TIMEOUT_CYCLES))
        else $error("Timeout counter past its limit");

endmodule

`default_nettype wire

// File: logic/ramBanks.sv
// Four word-wide RAM banks with byte-lane writes, registered reads and one shared ack
`timescale 1ns/1ps
`default_nettype none

module ramBanks #(
    parameter int RAM_ADDR_WIDTH = 8
) (
    input  logic                                wbClk_i,
    input  logic                                rst_i,
    // One select per bank from the decoder
    input  logic [fabricPkg::NUM_RAM_BANKS-1:0] bankCyc_i,
    input  logic                                stb_i,
    input  logic                                we_i,
    input  logic [RAM_ADDR_WIDTH-1:0]           wordAdr_i,
    input  fabricPkg::byteStb_t                 byteStb_i,
    input  fabricPkg::word_t                    wrDat_i,
    output fabricPkg::word_t                    rdDat_o,
    output logic                                ack_o
);

    localparam int RAM_DEPTH  = 2 ** RAM_ADDR_WIDTH;
    localparam int NUM_LANES  = fabricPkg::DATA_WIDTH / 8;
    localparam int BANK_WIDTH = $clog2(fabricPkg::NUM_RAM_BANKS);

    // Bank, word, lane
    logic [NUM_LANES-1:0][7:0] mem [fabricPkg::NUM_RAM_BANKS][RAM_DEPTH];

    logic                  ackQ;
    logic                  accept;
    logic [BANK_WIDTH-1:0] bankIdx;
    fabricPkg::word_t      rdQ;

    // --------------------
    // Handshake
    // --------------------

    assign accept = (|bankCyc_i) && stb_i && !ackQ;

    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            ackQ <= 1'b0;
        end
        else
        begin
            ackQ <= accept;
        end
    end

    // One-hot select to index
    always_comb
    begin
        bankIdx = '0;
        for (int b = 0; b < fabricPkg::NUM_RAM_BANKS; b++)
        begin
            if (bankCyc_i[b])
            begin
                bankIdx = BANK_WIDTH'(b);
            end
        end
    end

    // --------------------
    // Memory
    // --------------------

    // Only strobed lanes change
    always_ff @(posedge wbClk_i)
    begin
        if (accept && we_i)
        begin
            for (int lane = 0; lane < NUM_LANES; lane++)
            begin
                if (byteStb_i[lane])
                begin
                    mem[bankIdx][wordAdr_i][lane] <= wrDat_i[lane*8 +: 8];
                end
            end
        end
    end

    // Read word captured at the accept edge, valid during ack
    always_ff @(posedge wbClk_i)
    begin
        if (accept)
        begin
            rdQ <= mem[bankIdx][wordAdr_i];
        end
    end

    assign rdDat_o = rdQ;
    assign ack_o   = ackQ;

    // Decoder never selects two banks
    bankOneHot: assert property (@(posedge wbClk_i) disable iff (rst_i) $onehot0(bankCyc_i))
        else $error("Several RAM banks selected");

endmodule

`default_nettype wire

// File: logic/fpgaRegisters.sv
// Control register block with ID, revision and GPIO input, output and enable registers
`timescale 1ns/1ps
`default_nettype none

module fpgaRegisters #(
    parameter logic [31:0] DEVICE_ID = 32'h0,
    parameter logic [31:0] REV_LEVEL = 32'h0
) (
    input  logic                                 wbClk_i,
    input  logic                                 rst_i,
    // Bus side
    input  logic                                 cyc_i,
    input  logic                                 stb_i,
    input  logic                                 we_i,
    input  logic [fabricPkg::REG_ADDR_WIDTH-1:0] wordAdr_i,
    input  fabricPkg::byteStb_t                  byteStb_i,
    input  fabricPkg::word_t                     wrDat_i,
    output fabricPkg::word_t                     rdDat_o,
    output logic                                 ack_o,
    // GPIO
    input  fabricPkg::gpio_t                     gpioIn_i,
    output fabricPkg::gpio_t                     gpioOut_o,
    output fabricPkg::gpio_t                     gpioOe_o
);

    logic             ackQ;
    logic             accept;
    logic             laneWr;
    fabricPkg::gpio_t gpioMeta;
    fabricPkg::gpio_t gpioSync;
    fabricPkg::gpio_t gpioOutQ;
    fabricPkg::gpio_t gpioOeQ;

    // --------------------
    // Handshake
    // --------------------

    // New request only, skip the one already acked
    assign accept = cyc_i && stb_i && !ackQ;

    // GPIO registers only take lane 0
    assign laneWr = accept && we_i && byteStb_i[0];

    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            ackQ <= 1'b0;
        end
        else
        begin
            ackQ <= accept;
        end
    end

    // --------------------
    // GPIO
    // --------------------

    // Two flop synchronizer on the pad input
    always_ff @(posedge wbClk_i)
    begin
        gpioMeta <= gpioIn_i;
        gpioSync <= gpioMeta;
    end

    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            gpioOutQ <= '0;
            gpioOeQ  <= '0;
        end
        else if (laneWr)
        begin
            if (wordAdr_i == fabricPkg::GPIO_OUT_ADR)
            begin
                gpioOutQ <= wrDat_i[7:0];
            end
            if (wordAdr_i == fabricPkg::GPIO_OE_ADR)
            begin
                gpioOeQ <= wrDat_i[7:0];
            end
        end
    end

    // Read mux, address is held through the ack
    always_comb
    begin
        case (fabricPkg::regAddr_e'(wordAdr_i))
            fabricPkg::ID_ADR:       rdDat_o = DEVICE_ID;
            fabricPkg::REV_ADR:      rdDat_o = REV_LEVEL;
            fabricPkg::GPIO_IN_ADR:  rdDat_o = {24'h0, gpioSync};
            fabricPkg::GPIO_OUT_ADR: rdDat_o = {24'h0, gpioOutQ};
            fabricPkg::GPIO_OE_ADR:  rdDat_o = {24'h0, gpioOeQ};
            default:                 rdDat_o = fabricPkg::REG_DEF_VALUE;
        endcase
    end

    assign ack_o     = ackQ;
    assign gpioOut_o = gpioOutQ;
    assign gpioOe_o  = gpioOeQ;

    // Master holds the cycle until it sees the ack
    ackInCycle: assert property (@(posedge wbClk_i) disable iff (rst_i) ack_o |-> cyc_i)
        else $error("Register ack outside a bus cycle");

endmodule

`default_nettype wire

// File: logic/wbAddrDecoder.sv
// Bus address decoder selecting one target per region and merging acks and read data
`timescale 1ns/1ps
`default_nettype none

module wbAddrDecoder (
    input  fabricPkg::busAdr_t                adr_i,
    input  logic                              cyc_i,
    // Target returns
    input  fabricPkg::word_t                  regDat_i,
    input  fabricPkg::word_t                  ramDat_i,
    input  fabricPkg::word_t                  rsvDat_i,
    input  logic                              regAck_i,
    input  logic                              ramAck_i,
    input  logic                              rsvAck_i,
    // Target selects
    output logic                              regCyc_o,
    output logic                              rsvCyc_o,
    output logic [fabricPkg::NUM_RAM_BANKS-1:0] ramCyc_o,
    // Back to the master
    output fabricPkg::word_t                  rdDat_o,
    output logic                              ack_o
);

    fabricPkg::region_e region;

    // Top address bits pick the 8 KB region
    assign region = fabricPkg::region_e'(adr_i[fabricPkg::ADDR_WIDTH-1:fabricPkg::REGION_LSB]);

    // --------------------
    // Selects and read mux
    // --------------------

    always_comb
    begin
        regCyc_o = 1'b0;
        rsvCyc_o = 1'b0;
        ramCyc_o = '0;
        // Unmapped unless a region below claims it
        rdDat_o  = fabricPkg::DEFAULT_READ_VALUE;
        case (region)
            fabricPkg::REG_REGION:
            begin
                regCyc_o = cyc_i;
                rdDat_o  = regDat_i;
            end
            fabricPkg::RAM0_REGION:
            begin
                ramCyc_o[0] = cyc_i;
                rdDat_o     = ramDat_i;
            end
            fabricPkg::RAM1_REGION:
            begin
                ramCyc_o[1] = cyc_i;
                rdDat_o     = ramDat_i;
            end
            fabricPkg::RAM2_REGION:
            begin
                ramCyc_o[2] = cyc_i;
                rdDat_o     = ramDat_i;
            end
            fabricPkg::RAM3_REGION:
            begin
                ramCyc_o[3] = cyc_i;
                rdDat_o     = ramDat_i;
            end
            fabricPkg::RESERVED_REGION:
            begin
                rsvCyc_o = cyc_i;
                rdDat_o  = rsvDat_i;
            end
            default:
            begin
                // No select, timeout answers
                rdDat_o = fabricPkg::DEFAULT_READ_VALUE;
            end
        endcase
    end

    // Any target may finish the cycle
    assign ack_o = regAck_i | ramAck_i | rsvAck_i;

    // Acks from separate targets never overlap
    always_comb
    begin
        assert ($onehot0({regAck_i, ramAck_i, rsvAck_i}))
            else $error("More than one target acknowledged");
    end

endmodule

`default_nettype wire

// File: logic/fabricPkg.sv
// Fabric shared package with bus widths, region map, register offsets and read patterns
`default_nettype none

package fabricPkg;

    // --------------------
    // Bus widths
    // --------------------

    // Byte address into the 128 KB aperture
    localparam int ADDR_WIDTH = 17;
    localparam int DATA_WIDTH = 32;

    // Region field starts here, 8 KB per region
    localparam int REGION_LSB = 13;

    // Word offset width for register and reserved blocks
    localparam int REG_ADDR_WIDTH = 7;

    localparam int NUM_RAM_BANKS = 4;

    typedef logic [DATA_WIDTH-1:0]   word_t;
    typedef logic [ADDR_WIDTH-1:0]   busAdr_t;
    typedef logic [DATA_WIDTH/8-1:0] byteStb_t;
    typedef logic [7:0]              gpio_t;

    // --------------------
    // Address map
    // --------------------

    // Top address bits, values not listed are unmapped
    typedef enum logic [ADDR_WIDTH-REGION_LSB-1:0] {
        REG_REGION      = 4'd0,
        RAM0_REGION     = 4'd1,
        RAM1_REGION     = 4'd2,
        RAM2_REGION     = 4'd3,
        RAM3_REGION     = 4'd4,
        RESERVED_REGION = 4'd6
    } region_e;

    // Register block word offsets
    typedef enum logic [REG_ADDR_WIDTH-1:0] {
        ID_ADR       = 7'h00,
        REV_ADR      = 7'h01,
        GPIO_IN_ADR  = 7'h02,
        GPIO_OUT_ADR = 7'h03,
        GPIO_OE_ADR  = 7'h04
    } regAddr_e;

    // Reserved block word offsets, top of its window
    typedef enum logic [REG_ADDR_WIDTH-1:0] {
        CUST_PROD_ADR = 7'h7E,
        REVISIONS_ADR = 7'h7F
    } rsvAddr_e;

    // --------------------
    // Read patterns
    // --------------------

    // Marks an access to an unmapped region
    localparam word_t DEFAULT_READ_VALUE = 32'hBADF_ABAC;
    // Undefined register offset
    localparam word_t REG_DEF_VALUE      = 32'hFABD_EFAC;
    // Undefined reserved offset
    localparam word_t RSV_DEF_VALUE      = 32'hDEFF_ABAC;

endpackage

`default_nettype wire
